//--- common/lcd_cfg.svh
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

`define LCD_CYCLES_PER_US 50 // 50 MHz board clock

`define LCD_PULSE_US 1 // enable high time

`define LCD_POWER_ON_US 15000 // panel supply settle

`define LCD_WAKE1_US 5000 // after first 0x3

`define LCD_WAKE2_US 500 // after second 0x3

// third 0x3, bus width nibble, commands and characters
`define LCD_CMD_US 200

`define LCD_CLEAR_US 3000 // clear is slow

`endif

//--- common/lcd_bus_pkg.sv
package lcd_bus_pkg;

	typedef logic [7:0] lcd_byte_t;
	typedef logic [3:0] lcd_nibble_t;

	typedef enum logic [1:0] {
		wait_only, // settle time only, no pulse
		nibble,    // upper nibble of wr_byte
		byte_step  // upper then lower nibble
	} step_kind_t;

	// ctrl_lcd = {rs, rw, e}
	localparam int ctrl_e_bit = 0;
	localparam int ctrl_rw_bit = 1;
	localparam int ctrl_rs_bit = 2;

	localparam lcd_byte_t cmd_function_set = 8'h28; // 4-bit, 2 lines, 5x8
	localparam lcd_byte_t cmd_display_on = 8'h0F; // display, cursor, blink
	localparam lcd_byte_t cmd_clear = 8'h01;
	localparam lcd_byte_t cmd_entry_mode = 8'h06; // increment, no shift
	localparam lcd_byte_t cmd_row1_addr = 8'h80;
	localparam lcd_byte_t cmd_row2_addr = 8'hC0; // ddram 0x40

	localparam lcd_nibble_t nib_wake = 4'h3;
	localparam lcd_nibble_t nib_bus4 = 4'h2;

endpackage

//--- common/lcd_seq_pkg.sv
package lcd_seq_pkg;

	localparam int row_chars = 16;

	typedef logic [3:0] char_idx_t;
	typedef logic row_sel_t; // 0 row one, 1 row two

	typedef enum logic [3:0] {
		seq_power_on,
		seq_wake1,
		seq_wake2,
		seq_wake3,
		seq_bus4,
		seq_function_set,
		seq_display_on,
		seq_clear,
		seq_entry_mode,
		seq_row1_addr,
		seq_row1_text,
		seq_row2_addr,
		seq_row2_text,
		seq_done
	} seq_state_t;

endpackage

//--- rtl/lcd_text_rom.sv
`timescale 1ns/10ps

module lcd_text_rom
	import lcd_bus_pkg::*, lcd_seq_pkg::*;
(
	input  row_sel_t  row,
	input  char_idx_t col,
	output lcd_byte_t ch
);

	localparam logic [8*row_chars-1:0] row1_text = "Firmware loaded!";
	localparam logic [8*row_chars-1:0] row2_text = "0123456789abcdef";

	char_idx_t rev_col;

	// column 0 sits in the top byte of the string
	assign rev_col = char_idx_t'(row_chars - 1) - col;

	always_comb begin
		if (row)
			ch = row2_text[8*rev_col +: 8];
		else
			ch = row1_text[8*rev_col +: 8];
	end

endmodule

//--- sequencer/lcd_sequencer.sv
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_sequencer
	import lcd_bus_pkg::*, lcd_seq_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        done,
	input  lcd_byte_t   ch,
	output logic        start,
	output step_kind_t  kind,
	output lcd_byte_t   wr_byte,
	output logic        rs,
	output logic [15:0] settle_us,
	output row_sel_t    row,
	output char_idx_t   col
);

	seq_state_t state;
	seq_state_t state_nxt;
	logic       pending;
	logic       last_col;
	logic       text_step;

	assign last_col = (col == char_idx_t'(row_chars - 1));
	assign text_step = (state == seq_row1_text) || (state == seq_row2_text);
	assign row = (state == seq_row2_text);

	always_comb begin
		case (state)
			seq_power_on:     state_nxt = seq_wake1;
			seq_wake1:        state_nxt = seq_wake2;
			seq_wake2:        state_nxt = seq_wake3;
			seq_wake3:        state_nxt = seq_bus4;
			seq_bus4:         state_nxt = seq_function_set;
			seq_function_set: state_nxt = seq_display_on;
			seq_display_on:   state_nxt = seq_clear;
			seq_clear:        state_nxt = seq_entry_mode;
			seq_entry_mode:   state_nxt = seq_row1_addr;
			seq_row1_addr:    state_nxt = seq_row1_text;
			seq_row1_text:    state_nxt = last_col ? seq_row2_addr : seq_row1_text;
			seq_row2_addr:    state_nxt = seq_row2_text;
			seq_row2_text:    state_nxt = last_col ? seq_done : seq_row2_text;
			default:          state_nxt = seq_done;
		endcase
	end

	// request fields, stable for the whole step
	always_comb begin
		kind = byte_step;
		wr_byte = '0;
		rs = 1'b0;
		settle_us = 16'(`LCD_CMD_US);
		case (state)
			seq_power_on: begin
				kind = wait_only;
				settle_us = 16'(`LCD_POWER_ON_US);
			end
			seq_wake1: begin
				kind = nibble;
				wr_byte = {nib_wake, 4'h0};
				settle_us = 16'(`LCD_WAKE1_US);
			end
			seq_wake2: begin
				kind = nibble;
				wr_byte = {nib_wake, 4'h0};
				settle_us = 16'(`LCD_WAKE2_US);
			end
			seq_wake3: begin
				kind = nibble;
				wr_byte = {nib_wake, 4'h0};
			end
			seq_bus4: begin
				kind = nibble;
				wr_byte = {nib_bus4, 4'h0};
			end
			seq_function_set: wr_byte = cmd_function_set;
			seq_display_on:   wr_byte = cmd_display_on;
			seq_clear: begin
				wr_byte = cmd_clear;
				settle_us = 16'(`LCD_CLEAR_US);
			end
			seq_entry_mode: wr_byte = cmd_entry_mode;
			seq_row1_addr:  wr_byte = cmd_row1_addr;
			seq_row2_addr:  wr_byte = cmd_row2_addr;
			seq_row1_text, seq_row2_text: begin
				wr_byte = ch;
				rs = 1'b1; // data register
			end
			default: kind = wait_only; // idle, never started
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= seq_power_on;
			pending <= 1'b1;
			start <= 1'b0;
			col <= '0;
		end else begin
			start <= 1'b0;
			if (pending) begin
				start <= 1'b1; // kick off power-on wait
				pending <= 1'b0;
			end
			if (done) begin
				state <= state_nxt;
				start <= (state_nxt != seq_done);
				if (text_step)
					col <= last_col ? '0 : col + 1'b1;
			end
		end
	end

endmodule

//--- writer/lcd_nibble_writer.sv
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_nibble_writer
	import lcd_bus_pkg::*;
#(
	parameter int cycles_per_us = `LCD_CYCLES_PER_US
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  step_kind_t  kind,
	input  lcd_byte_t   wr_byte,
	input  logic        rs,
	input  logic [15:0] settle_us,
	output logic        done,
	output logic [2:0]  ctrl_lcd,
	output lcd_nibble_t data_lcd
);

	localparam int pre_w = (cycles_per_us > 1) ? $clog2(cycles_per_us) : 1;
	localparam logic [pre_w-1:0] pre_last = pre_w'(cycles_per_us - 1);
	localparam logic [15:0] hi_pulse_end = 16'(`LCD_PULSE_US);
	localparam logic [15:0] hi_hold_end = 16'(2 * `LCD_PULSE_US);
	localparam logic [15:0] lo_pulse_end = 16'(3 * `LCD_PULSE_US);
	localparam logic [15:0] lo_hold_end = 16'(4 * `LCD_PULSE_US);

	logic             busy;
	logic             busy_nxt;
	logic [pre_w-1:0] pre_cnt;
	logic [pre_w-1:0] pre_nxt;
	logic [15:0]      us_cnt;
	logic [15:0]      us_nxt;
	logic             e_nxt;
	logic             done_nxt;
	lcd_nibble_t      data_nxt;
	logic [2:0]       ctrl_nxt;

	// prescaler and microsecond counter
	always_comb begin
		busy_nxt = busy;
		pre_nxt = pre_cnt;
		us_nxt = us_cnt;
		if (!busy) begin
			if (start) begin
				busy_nxt = 1'b1;
				pre_nxt = '0;
				us_nxt = '0;
			end
		end else if (pre_cnt == pre_last) begin
			pre_nxt = '0;
			if (us_cnt == settle_us - 16'd1)
				busy_nxt = 1'b0;
			else
				us_nxt = us_cnt + 16'd1;
		end else begin
			pre_nxt = pre_cnt + 1'b1;
		end
	end

	// pins follow the next count so they line up with it when registered
	always_comb begin
		e_nxt = 1'b0;
		data_nxt = '0;
		if (busy_nxt && kind != wait_only) begin
			if (us_nxt < hi_hold_end) begin
				e_nxt = (us_nxt < hi_pulse_end);
				data_nxt = wr_byte[7:4];
			end else if (kind == byte_step && us_nxt < lo_hold_end) begin
				e_nxt = (us_nxt < lo_pulse_end);
				data_nxt = wr_byte[3:0];
			end
		end
		done_nxt = busy_nxt && (pre_nxt == pre_last) && (us_nxt == settle_us - 16'd1);
		ctrl_nxt = '0;
		ctrl_nxt[ctrl_e_bit] = e_nxt;
		ctrl_nxt[ctrl_rs_bit] = e_nxt & rs; // rs only with e high
		ctrl_nxt[ctrl_rw_bit] = 1'b0; // write only
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			pre_cnt <= '0;
			us_cnt <= '0;
			done <= 1'b0;
			ctrl_lcd <= '0;
			data_lcd <= '0;
		end else begin
			busy <= busy_nxt;
			pre_cnt <= pre_nxt;
			us_cnt <= us_nxt;
			done <= done_nxt;
			ctrl_lcd <= ctrl_nxt;
			data_lcd <= data_nxt;
		end
	end

endmodule

//--- rtl/lcd_top.sv
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_top
	import lcd_bus_pkg::*, lcd_seq_pkg::*;
#(
	parameter int cycles_per_us = `LCD_CYCLES_PER_US
) (
	input  logic        clk,
	input  logic        rst,
	output logic [2:0]  ctrl_lcd,
	output lcd_nibble_t data_lcd
);

	logic        start;
	logic        done;
	step_kind_t  kind;
	lcd_byte_t   wr_byte;
	logic        rs;
	logic [15:0] settle_us;
	row_sel_t    row;
	char_idx_t   col;
	lcd_byte_t   ch;

	lcd_sequencer u_sequencer (
		.clk       (clk),
		.rst       (rst),
		.done      (done),
		.ch        (ch),
		.start     (start),
		.kind      (kind),
		.wr_byte   (wr_byte),
		.rs        (rs),
		.settle_us (settle_us),
		.row       (row),
		.col       (col)
	);

	lcd_text_rom u_text_rom (
		.row (row),
		.col (col),
		.ch  (ch)
	);

	lcd_nibble_writer #(
		.cycles_per_us (cycles_per_us)
	) u_writer (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.kind      (kind),
		.wr_byte   (wr_byte),
		.rs        (rs),
		.settle_us (settle_us),
		.done      (done),
		.ctrl_lcd  (ctrl_lcd),
		.data_lcd  (data_lcd)
	);

endmodule

//--- verification/lcd_assert.sv
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_assert
	import lcd_bus_pkg::*;
#(
	parameter int pulse_cycles = `LCD_CYCLES_PER_US * `LCD_PULSE_US
) (
	input logic        clk,
	input logic        rst,
	input logic [2:0]  ctrl_lcd,
	input lcd_nibble_t data_lcd
);

	int low_cnt; // low samples before the current one

	always_ff @(posedge clk) begin
		if (rst || ctrl_lcd[ctrl_e_bit])
			low_cnt <= 0;
		else
			low_cnt <= low_cnt + 1;
	end

	rw_low: assert property (@(posedge clk) disable iff (rst) !ctrl_lcd[ctrl_rw_bit])
		else $error("rw went high");

	data_idle: assert property (@(posedge clk) disable iff (rst)
		(!ctrl_lcd[ctrl_e_bit] && low_cnt >= pulse_cycles) |-> data_lcd == '0)
		else $error("data not cleared after the hold time");

	rs_with_e: assert property (@(posedge clk) disable iff (rst)
		!ctrl_lcd[ctrl_e_bit] |-> !ctrl_lcd[ctrl_rs_bit])
		else $error("rs high while e low");

endmodule

bind lcd_top lcd_assert #(
	.pulse_cycles (cycles_per_us * `LCD_PULSE_US)
) u_assert (
	.clk      (clk),
	.rst      (rst),
	.ctrl_lcd (ctrl_lcd),
	.data_lcd (data_lcd)
);

//--- verification/lcd_tb.sv
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_tb
	import lcd_bus_pkg::*;
;

	localparam int cpu = 2;
	localparam int pulse_cycles = cpu * `LCD_PULSE_US;
	localparam int tail_us = 1000;
	// 39 steps settle for the command time, wake-up and text included
	localparam int total_us = `LCD_POWER_ON_US + `LCD_WAKE1_US + `LCD_WAKE2_US
		+ `LCD_CLEAR_US + 39 * `LCD_CMD_US + tail_us;
	localparam int timeout_ns = total_us * cpu * 100 * 11 / 10;

	logic        clk;
	logic        rst;
	logic [2:0]  ctrl_lcd;
	lcd_nibble_t data_lcd;

	int          errors;
	int          cyc;
	int          last_rise;
	int          high_len;
	int          rise_gap;
	int          min_gap;
	int          step_offset; // last rise of the previous write after its first rise
	logic        e_prev;
	logic        rs_hi;
	lcd_nibble_t data_hi;
	logic [4:0]  nib_q[$]; // {rs, nibble}
	int          width_q[$];
	int          gap_q[$];
	string       row1_text;
	string       row2_text;

	lcd_top #(
		.cycles_per_us (cpu)
	) dut (
		.clk      (clk),
		.rst      (rst),
		.ctrl_lcd (ctrl_lcd),
		.data_lcd (data_lcd)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// pins are registered, so they are settled at the falling edge
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (rst) begin
			last_rise = cyc;
			e_prev = 1'b0;
		end else if (ctrl_lcd[ctrl_e_bit]) begin
			if (!e_prev) begin
				rise_gap = cyc - last_rise;
				last_rise = cyc;
				high_len = 0;
			end
			high_len = high_len + 1;
			rs_hi = ctrl_lcd[ctrl_rs_bit];
			data_hi = data_lcd;
			e_prev = 1'b1;
		end else begin
			if (e_prev) begin
				nib_q.push_back({rs_hi, data_hi});
				width_q.push_back(high_len);
				gap_q.push_back(rise_gap);
			end
			e_prev = 1'b0;
		end
	end

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			errors++;
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic take_nibble(output logic [4:0] nib, output int gap);
		while (nib_q.size() == 0)
			@(negedge clk);
		nib = nib_q.pop_front();
		gap = gap_q.pop_front();
		check_value("pulse_width", pulse_cycles, width_q.pop_front());
	endtask

	task automatic expect_write(input string name, input logic [7:0] value,
		input bit two_nibbles, input bit rs, input int settle_us);
		logic [4:0] nib;
		int gap;
		take_nibble(nib, gap);
		check_value(name, int'({rs, value[7:4]}), int'(nib));
		gap = gap + step_offset; // from the first rise of the previous write
		assert (gap >= min_gap) else begin
			errors++;
			$display("%s came %0d cycles after the previous write, at least %0d needed",
				name, gap, min_gap);
		end
		step_offset = 0;
		if (two_nibbles) begin
			take_nibble(nib, gap);
			check_value(name, int'({rs, value[3:0]}), int'(nib));
			check_value({name, "_low_gap"}, 2 * pulse_cycles, gap);
			step_offset = gap;
		end
		min_gap = settle_us * cpu;
	endtask

	task automatic test_power_on_quiet();
		repeat (8) begin
			@(negedge clk);
			check_value("power_on", 0, int'({ctrl_lcd, data_lcd}));
		end
		rst = 1'b0;
		repeat (`LCD_POWER_ON_US * cpu) begin
			@(negedge clk);
			check_value("power_on", 0, int'({ctrl_lcd, data_lcd}));
		end
		check_value("power_on_pulses", 0, nib_q.size());
		min_gap = `LCD_POWER_ON_US * cpu;
	endtask

	task automatic test_wake_nibbles();
		expect_write("wake1", 8'h30, 1'b0, 1'b0, `LCD_WAKE1_US);
		expect_write("wake2", 8'h30, 1'b0, 1'b0, `LCD_WAKE2_US);
		expect_write("wake3", 8'h30, 1'b0, 1'b0, `LCD_CMD_US);
		expect_write("bus4", 8'h20, 1'b0, 1'b0, `LCD_CMD_US);
	endtask

	task automatic test_commands();
		expect_write("function_set", 8'h28, 1'b1, 1'b0, `LCD_CMD_US);
		expect_write("display_on", 8'h0F, 1'b1, 1'b0, `LCD_CMD_US);
		expect_write("clear", 8'h01, 1'b1, 1'b0, `LCD_CLEAR_US);
		expect_write("entry_mode", 8'h06, 1'b1, 1'b0, `LCD_CMD_US);
		expect_write("row1_addr", 8'h80, 1'b1, 1'b0, `LCD_CMD_US);
	endtask

	task automatic test_text();
		for (int i = 0; i < 16; i++)
			expect_write("row1_text", row1_text[i], 1'b1, 1'b1, `LCD_CMD_US);
		expect_write("row2_addr", 8'hC0, 1'b1, 1'b0, `LCD_CMD_US);
		for (int i = 0; i < 16; i++)
			expect_write("row2_text", row2_text[i], 1'b1, 1'b1, `LCD_CMD_US);
	endtask

	task automatic test_idle_tail();
		repeat (tail_us * cpu) begin
			@(negedge clk);
			check_value("idle_e", 0, int'(ctrl_lcd[ctrl_e_bit]));
		end
		check_value("idle_pulses", 0, nib_q.size());
	endtask

	initial begin
		errors = 0;
		cyc = 0;
		last_rise = 0;
		high_len = 0;
		rise_gap = 0;
		min_gap = 0;
		step_offset = 0;
		e_prev = 1'b0;
		rs_hi = 1'b0;
		data_hi = '0;
		row1_text = "Firmware loaded!";
		row2_text = "0123456789abcdef";
		rst = 1'b1;
		test_power_on_quiet();
		test_wake_nibbles();
		test_commands();
		test_text();
		test_idle_tail();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("timeout: the panel sequence did not finish within %0d ns", timeout_ns);
		$display("errors: %0d", errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- project.f
+incdir+common
common/lcd_bus_pkg.sv
common/lcd_seq_pkg.sv
rtl/lcd_text_rom.sv
sequencer/lcd_sequencer.sv
writer/lcd_nibble_writer.sv
rtl/lcd_top.sv
verification/lcd_assert.sv
verification/lcd_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -f project.f --top-module lcd_tb > build.log 2>&1 &&
./obj_dir/Vlcd_tb > sim.log 2>&1 ;
cat sim.log 2>/dev/null ;
grep -q "Simulation completed successfully" sim.log && echo "PASS" ||
{ echo "FAIL (see build.log and sim.log)"; exit 1; }
